//--- verilog/so_pkg.sv
/*
  Shared widths, opcodes and word layout of the self-output datapath.
  The payload of a tagged word is read as data or as config by its opcode.
  The requant helper assumes the product of accumulator and multiplier
  fits PROD_W bits, which holds for a 32-bit signed value times a
  32-bit unsigned multiplier.
*/

package so_pkg;

  // ========================================================================
  // Widths
  // ========================================================================
  localparam int ACC_W     = 32;
  localparam int RES_W     = 8;
  localparam int SCALE_M_W = 32;
  localparam int PAYLOAD_W = ACC_W + RES_W;
  // Shift field fills what the multiplier leaves of the payload
  localparam int SCALE_E_W = PAYLOAD_W - SCALE_M_W;
  localparam int SUM_W     = 22;
  localparam int OP_W      = 2;
  localparam int ROWS_W    = 8;
  localparam int PROD_W    = ACC_W + SCALE_M_W;

  // Output credits after reset
  localparam int CREDIT_W = 3;
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(4);

  // Saturation and clip limits, widened to the product width
  localparam logic signed [PROD_W-1:0] SUM_MAX = (64'sd1 <<< (SUM_W - 1)) - 64'sd1;
  localparam logic signed [PROD_W-1:0] SUM_MIN = -(64'sd1 <<< (SUM_W - 1));
  localparam logic signed [PROD_W-1:0] OUT_MAX = (64'sd1 <<< (RES_W - 1)) - 64'sd1;
  localparam logic signed [PROD_W-1:0] OUT_MIN = -(64'sd1 <<< (RES_W - 1));

  // ========================================================================
  // Tagged input word
  // ========================================================================
  typedef enum logic [OP_W-1:0] {
    OP_DATA      = 2'd0,
    OP_DATA_LAST = 2'd1,
    OP_CFG_MM    = 2'd2,
    OP_CFG_OUT   = 2'd3
  } op_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] acc;
    logic signed [RES_W-1:0] residual;
  } data_fields_t;

  typedef struct packed {
    logic [SCALE_M_W-1:0] m;
    logic [SCALE_E_W-1:0] e;
  } cfg_fields_t;

  typedef union packed {
    data_fields_t data;
    cfg_fields_t  cfg;
  } payload_u;

  // Opcode sits in the top two bits
  typedef struct packed {
    op_t      op;
    payload_u payload;
  } in_word_t;

  // Signed value times unsigned multiplier, arithmetic shift right
  // Shifts of 63 and up leave only the sign
  function automatic logic signed [PROD_W-1:0] requant(
    input logic signed [ACC_W-1:0]     val,
    input logic        [SCALE_M_W-1:0] mult,
    input logic        [SCALE_E_W-1:0] shift
  );
    logic signed [PROD_W-1:0] prod;
    prod = PROD_W'(val) * $signed({{(PROD_W-SCALE_M_W){1'b0}}, mult});
    if (shift >= 63) begin
      return {PROD_W{prod[PROD_W-1]}};
    end
    return prod >>> shift;
  endfunction

endpackage

//--- verilog/so_data_if.sv
/*
  Decoded data items from decode to execute.
  Each item carries both scales it was accepted under.
  advance is the pipeline-wide load enable, driven from the result end.
*/

`timescale 1ns/1ps

interface so_data_if;

  logic                              valid;
  logic signed [so_pkg::ACC_W-1:0]   acc;
  logic signed [so_pkg::RES_W-1:0]   residual;
  logic                              last;

  // Matmul requant scale, used by execute stage 1
  logic [so_pkg::SCALE_M_W-1:0]      m_mm;
  logic [so_pkg::SCALE_E_W-1:0]      e_mm;

  // Output requant scale, passed on to result
  logic [so_pkg::SCALE_M_W-1:0]      m_out;
  logic [so_pkg::SCALE_E_W-1:0]      e_out;

  logic                              advance;

  modport producer (
    output valid, acc, residual, last, m_mm, e_mm, m_out, e_out,
    input  advance
  );

  modport consumer (
    input  valid, acc, residual, last, m_mm, e_mm, m_out, e_out,
    output advance
  );

endinterface

//--- verilog/so_sum_if.sv
/*
  Saturated 22-bit sums from execute to result.
  The output scale travels with each sum.
  advance comes from the credit logic in result.
*/

`timescale 1ns/1ps

interface so_sum_if;

  logic                              valid;
  logic signed [so_pkg::SUM_W-1:0]   sum;
  logic                              last;

  // Output requant scale stamped at decode
  logic [so_pkg::SCALE_M_W-1:0]      m_out;
  logic [so_pkg::SCALE_E_W-1:0]      e_out;

  logic                              advance;

  modport producer (
    output valid, sum, last, m_out, e_out,
    input  advance
  );

  modport consumer (
    input  valid, sum, last, m_out, e_out,
    output advance
  );

endinterface

//--- verilog/so_decode.sv
/*
  Input register and opcode decode.
  A word is accepted when in_valid and in_ready are high on a clock edge.
  Config words take effect for data words accepted after them and issue
  no item. Scales come out of reset as multiplier 1, shift 0.
*/

`timescale 1ns/1ps

module so_decode (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  so_pkg::in_word_t in_word,
  output logic             in_ready,
  so_data_if.producer      dp
);

  logic                           word_valid;
  so_pkg::in_word_t               word_q;
  logic                           is_data;

  // Live scale registers
  logic [so_pkg::SCALE_M_W-1:0]   mm_m;
  logic [so_pkg::SCALE_E_W-1:0]   mm_e;
  logic [so_pkg::SCALE_M_W-1:0]   out_m;
  logic [so_pkg::SCALE_E_W-1:0]   out_e;

  // Whole pipeline moves together, so ready is just advance
  assign in_ready = dp.advance;

  // ========================================================================
  // Input register
  // ========================================================================
  always_ff @(posedge clk) begin
    if (!rstn) begin
      word_valid <= 1'b0;
    end else if (dp.advance) begin
      word_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.advance && in_valid) begin
      word_q <= in_word;
    end
  end

  // ========================================================================
  // Scale registers
  // ========================================================================
  // Config applies as it leaves the input register
  // Data word loaded on the same edge sees the new value
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mm_m  <= 1;
      mm_e  <= '0;
      out_m <= 1;
      out_e <= '0;
    end else if (dp.advance && word_valid) begin
      case (word_q.op)
        so_pkg::OP_CFG_MM: begin
          mm_m <= word_q.payload.cfg.m;
          mm_e <= word_q.payload.cfg.e;
        end
        so_pkg::OP_CFG_OUT: begin
          out_m <= word_q.payload.cfg.m;
          out_e <= word_q.payload.cfg.e;
        end
        default: begin
        end
      endcase
    end
  end

  // ========================================================================
  // Item to execute
  // ========================================================================
  assign is_data = (word_q.op == so_pkg::OP_DATA) || (word_q.op == so_pkg::OP_DATA_LAST);

  assign dp.valid    = word_valid && is_data;
  assign dp.acc      = word_q.payload.data.acc;
  assign dp.residual = word_q.payload.data.residual;
  assign dp.last     = (word_q.op == so_pkg::OP_DATA_LAST);

  // Stamp current scales onto the item
  assign dp.m_mm  = mm_m;
  assign dp.e_mm  = mm_e;
  assign dp.m_out = out_m;
  assign dp.e_out = out_e;

endmodule

//--- verilog/so_requant_add.sv
/*
  Matmul requant, residual add and saturation, two register stages.
  Stage 1 keeps the full 64-bit shifted product, so no bits are lost
  before the add. Stage 2 saturates to the signed 22-bit layer-norm range.
  Both stages hold their item while advance is low.
*/

`timescale 1ns/1ps

module so_requant_add (
  input  logic        clk,
  input  logic        rstn,
  so_data_if.consumer dp,
  so_sum_if.producer  sp
);

  // Stage 1 registers
  logic                              s1_valid;
  logic signed [so_pkg::PROD_W-1:0]  s1_scaled;
  logic signed [so_pkg::RES_W-1:0]   s1_residual;
  logic                              s1_last;
  logic [so_pkg::SCALE_M_W-1:0]      s1_m_out;
  logic [so_pkg::SCALE_E_W-1:0]      s1_e_out;

  // Stage 2 combinational
  logic signed [so_pkg::PROD_W-1:0]  res_ext;
  logic signed [so_pkg::PROD_W-1:0]  sum_wide;
  logic signed [so_pkg::SUM_W-1:0]   sum_sat;

  // Stall passes straight through
  assign dp.advance = sp.advance;

  // ========================================================================
  // Stage 1: requant with the mm scale
  // ========================================================================
  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
    end else if (sp.advance) begin
      s1_valid <= dp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sp.advance) begin
      s1_scaled   <= so_pkg::requant(dp.acc, dp.m_mm, dp.e_mm);
      s1_residual <= dp.residual;
      s1_last     <= dp.last;
      s1_m_out    <= dp.m_out;
      s1_e_out    <= dp.e_out;
    end
  end

  // ========================================================================
  // Stage 2: residual add and saturation
  // ========================================================================
  // Residual x256 then >>8 upstream reduces to sign extension
  assign res_ext = {{(so_pkg::PROD_W-so_pkg::RES_W){s1_residual[so_pkg::RES_W-1]}},
                    s1_residual};

  // 64 bits leave headroom for the 8-bit residual
  assign sum_wide = s1_scaled + res_ext;

  always_comb begin
    if (sum_wide > so_pkg::SUM_MAX) begin
      sum_sat = so_pkg::SUM_MAX[so_pkg::SUM_W-1:0];
    end else if (sum_wide < so_pkg::SUM_MIN) begin
      sum_sat = so_pkg::SUM_MIN[so_pkg::SUM_W-1:0];
    end else begin
      sum_sat = sum_wide[so_pkg::SUM_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sp.valid <= 1'b0;
    end else if (sp.advance) begin
      sp.valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sp.advance) begin
      sp.sum   <= sum_sat;
      sp.last  <= s1_last;
      sp.m_out <= s1_m_out;
      sp.e_out <= s1_e_out;
    end
  end

endmodule

//--- verilog/so_result.sv
/*
  Output requant, int8 clip, credits and row count.
  out_valid is a one-cycle pulse and each pulse spends one credit.
  The consumer returns credits on out_credit, one per cycle at most,
  and never more than it was given. rows_done wraps at 2^ROWS_W.
*/

`timescale 1ns/1ps

module so_result (
  input  logic                      clk,
  input  logic                      rstn,
  so_sum_if.consumer                sp,
  output logic                      out_valid,
  output logic [so_pkg::RES_W-1:0]  out_data,
  output logic                      out_last,
  input  logic                      out_credit,
  output logic [so_pkg::ROWS_W-1:0] rows_done
);

  logic [so_pkg::CREDIT_W-1:0]       credits;
  logic                              issue;
  logic signed [so_pkg::PROD_W-1:0]  scaled;
  logic [so_pkg::RES_W-1:0]          clipped;

  // ========================================================================
  // Credits and stall
  // ========================================================================
  // A credit returning this cycle can be spent at once
  assign sp.advance = (credits != '0) || out_credit;
  assign issue      = sp.advance && sp.valid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      credits <= so_pkg::CREDIT_MAX;
    end else begin
      case ({issue, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // ========================================================================
  // Output requant and clip
  // ========================================================================
  assign scaled = so_pkg::requant(sp.sum, sp.m_out, sp.e_out);

  always_comb begin
    if (scaled > so_pkg::OUT_MAX) begin
      clipped = so_pkg::OUT_MAX[so_pkg::RES_W-1:0];
    end else if (scaled < so_pkg::OUT_MIN) begin
      clipped = so_pkg::OUT_MIN[so_pkg::RES_W-1:0];
    end else begin
      clipped = scaled[so_pkg::RES_W-1:0];
    end
  end

  // ========================================================================
  // Output register and row counter
  // ========================================================================
  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      rows_done <= '0;
    end else begin
      // No credit means no pulse and the item waits upstream
      out_valid <= issue;
      out_last  <= issue && sp.last;
      if (issue && sp.last) begin
        rows_done <= rows_done + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      out_data <= clipped;
    end
  end

endmodule

//--- verilog/self_output_top.sv
/*
  Self-output datapath: matmul requant, residual add, saturation to
  22 bits, output requant and int8 clip. Four cycles from an accepted
  data word to out_valid when credits are free. Zero credits freeze
  the whole pipeline and pull in_ready low.
*/

`timescale 1ns/1ps

module self_output_top (
  input  logic                      clk,
  input  logic                      rstn,

  // Tagged input stream
  input  logic                      in_valid,
  input  so_pkg::in_word_t          in_word,
  output logic                      in_ready,

  // Credit-based output stream
  output logic                      out_valid,
  output logic [so_pkg::RES_W-1:0]  out_data,
  output logic                      out_last,
  input  logic                      out_credit,

  // Finished token rows
  output logic [so_pkg::ROWS_W-1:0] rows_done
);

  so_data_if data_if ();
  so_sum_if  sum_if ();

  // Split words, hold scales
  so_decode decode_inst (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .in_word  (in_word),
    .in_ready (in_ready),
    .dp       (data_if.producer)
  );

  // Requant, add, saturate
  so_requant_add execute_inst (
    .clk  (clk),
    .rstn (rstn),
    .dp   (data_if.consumer),
    .sp   (sum_if.producer)
  );

  // Requant, clip, credits
  so_result result_inst (
    .clk        (clk),
    .rstn       (rstn),
    .sp         (sum_if.consumer),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .out_credit (out_credit),
    .rows_done  (rows_done)
  );

endmodule

//--- dv/so_tb_model.svh
/*
  Reference model of the self-output datapath, included inside the
  testbench module. Expected outputs queue up in input order, each with
  the scales the model holds when its data word is accepted.
*/

`ifndef SO_TB_MODEL_SVH
`define SO_TB_MODEL_SVH

// Expected outputs as {last, data}
logic [8:0]  exp_q[$];

// Scales as the model sees them
logic [31:0] mdl_m_mm;
logic [7:0]  mdl_e_mm;
logic [31:0] mdl_m_out;
logic [7:0]  mdl_e_out;

// Signed value times unsigned multiplier, then arithmetic shift
function automatic longint scale_shift(input longint val, input logic [31:0] mult,
                                       input logic [7:0] shift);
  longint prod;
  prod = val * longint'({32'd0, mult});
  // Only the sign survives a shift this long
  if (shift >= 8'd63)
    return (prod < 0) ? -64'sd1 : 64'sd0;
  return prod >>> shift;
endfunction

// Signed 22-bit layer-norm input range
function automatic longint sat_sum(input longint v);
  if (v > 64'sd2097151)
    return 64'sd2097151;
  else if (v < -64'sd2097152)
    return -64'sd2097152;
  return v;
endfunction

// Signed 8-bit output range
function automatic logic [7:0] clip_out(input longint v);
  if (v > 64'sd127)
    return 8'h7f;
  else if (v < -64'sd128)
    return 8'h80;
  return v[7:0];
endfunction

// One accepted word, config or data
task automatic model_accept(input so_pkg::in_word_t w);
  longint     sum;
  logic [7:0] q;
  case (w.op)
    so_pkg::OP_CFG_MM: begin
      mdl_m_mm = w.payload.cfg.m;
      mdl_e_mm = w.payload.cfg.e;
    end
    so_pkg::OP_CFG_OUT: begin
      mdl_m_out = w.payload.cfg.m;
      mdl_e_out = w.payload.cfg.e;
    end
    default: begin
      // Residual scaled by 256 then shifted by 8 is its sign extension
      sum = sat_sum(scale_shift(longint'($signed(w.payload.data.acc)), mdl_m_mm, mdl_e_mm)
                    + longint'($signed(w.payload.data.residual)));
      q = clip_out(scale_shift(sum, mdl_m_out, mdl_e_out));
      exp_q.push_back({w.op == so_pkg::OP_DATA_LAST, q});
    end
  endcase
endtask

`endif

//--- dv/tb_self_output.sv
/*
  Testbench for the self-output datapath. Inputs change on the falling
  edge, concurrent assertions check on the rising edge. Credits return
  0 to 3 cycles after each output, or are held off during the
  back-pressure test. Random stimulus uses $random with a fixed seed.
*/

`timescale 1ns/1ps

module tb_self_output;

  localparam int RESET_CYCLES = 8;
  localparam int T2_WORDS     = 200;
  localparam int HOLD_WORDS   = 10;
  localparam int HOLD_CYCLES  = 30;
  localparam int ROWS         = 4;
  localparam int ROW_LEN      = 5;
  // Words, configs, idles and stalls of every test plus drains
  localparam int STIM_CYCLES  = RESET_CYCLES + 2 * T2_WORDS + 40 + HOLD_CYCLES + HOLD_WORDS
                                + ROWS * ROW_LEN + 50;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 200;

  logic                      clk;
  logic                      rstn;
  logic                      in_valid;
  so_pkg::in_word_t          in_word;
  logic                      in_ready;
  logic                      out_valid;
  logic [so_pkg::RES_W-1:0]  out_data;
  logic                      out_last;
  logic                      out_credit;
  logic [so_pkg::ROWS_W-1:0] rows_done;

  int seed;
  // Credit delays draw from a stream of their own
  int credit_seed;
  int errors;
  int checked;
  int cycles;
  int i;
  // Outputs seen minus credits returned
  int outstanding;
  // Cycle at which each pending credit goes back
  int credit_due[$];
  logic [so_pkg::ROWS_W-1:0] rows_model;
  logic       exp_avail;
  logic [7:0] exp_data;
  logic       exp_last;
  logic       hold_credits;
  logic       fast_credit;
  logic       check_latency;

  `include "so_tb_model.svh"

  self_output_top self_output_top_inst (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .out_credit (out_credit),
    .rows_done  (rows_done)
  );

  always #2 clk = ~clk;

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("FAIL %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycles);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error at cycle %0d: %s", cycles, what);
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // 0 to 3 cycles before a credit goes back
  function automatic int credit_delay();
    return $unsigned($random(credit_seed)) % 4;
  endfunction

  function automatic so_pkg::in_word_t data_word(input logic last, input logic [31:0] acc,
                                                 input logic [7:0] res);
    so_pkg::in_word_t w;
    w.op = last ? so_pkg::OP_DATA_LAST : so_pkg::OP_DATA;
    w.payload.data.acc = acc;
    w.payload.data.residual = res;
    return w;
  endfunction

  function automatic so_pkg::in_word_t cfg_word(input so_pkg::op_t op, input logic [31:0] m,
                                                input logic [7:0] e);
    so_pkg::in_word_t w;
    w.op = op;
    w.payload.cfg.m = m;
    w.payload.cfg.e = e;
    return w;
  endfunction

  // Hold the word until the edge that takes it
  task automatic send_word(input so_pkg::in_word_t w);
    @(negedge clk);
    in_valid = 1'b1;
    in_word  = w;
    @(posedge clk);
    while (!in_ready)
      @(posedge clk);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // Queue empty and every credit back
  task automatic wait_drained();
    idle(1);
    while (exp_q.size() > 0 || outstanding != 0)
      @(negedge clk);
  endtask

  // ==========================================================================
  // Model update, output bookkeeping and credit return
  // ==========================================================================
  always @(posedge clk) begin
    cycles++;
    if (!rstn) begin
      exp_q.delete();
      credit_due.delete();
      outstanding = 0;
      rows_model  = '0;
      mdl_m_mm    = 32'd1;
      mdl_e_mm    = 8'd0;
      mdl_m_out   = 32'd1;
      mdl_e_out   = 8'd0;
    end else begin
      if (out_valid) begin
        checked++;
        if (exp_q.size() > 0) begin
          rows_model = rows_model + exp_q[0][8];
          void'(exp_q.pop_front());
        end
        credit_due.push_back(cycles + (fast_credit ? 0 : credit_delay()));
      end
      outstanding = outstanding + out_valid - out_credit;
      if (in_valid && in_ready)
        model_accept(in_word);
    end
    exp_avail = (exp_q.size() > 0);
    exp_data  = exp_avail ? exp_q[0][7:0] : 8'h00;
    exp_last  = exp_avail ? exp_q[0][8] : 1'b0;
  end

  // At most one credit per cycle
  always @(negedge clk) begin
    if (rstn && !hold_credits && credit_due.size() > 0 && credit_due[0] <= cycles) begin
      void'(credit_due.pop_front());
      out_credit = 1'b1;
    end else begin
      out_credit = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d outputs checked, %0d errors",
               cycles, checked, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ==========================================================================
  // Assertions
  // ==========================================================================
  // Reset state through the cycle after release
  assert property (@(posedge clk) !rstn |=> !out_valid)
    else report_mismatch("out_valid", $sampled(out_valid), 0);
  assert property (@(posedge clk) !rstn |=> rows_done == 0)
    else report_mismatch("rows_done", $sampled(rows_done), 0);
  assert property (@(posedge clk) !rstn |=> in_ready)
    else report_mismatch("in_ready", $sampled(in_ready), 1);

  assert property (@(posedge clk) disable iff (!rstn) out_valid |-> exp_avail)
    else report_problem("an output appeared with no expected value left");
  assert property (@(posedge clk) disable iff (!rstn)
    out_valid && exp_avail |-> out_data == exp_data)
    else report_mismatch("out_data", $sampled(out_data), $sampled(exp_data));
  assert property (@(posedge clk) disable iff (!rstn)
    out_valid && exp_avail |-> out_last == exp_last)
    else report_mismatch("out_last", $sampled(out_last), $sampled(exp_last));
  assert property (@(posedge clk) disable iff (!rstn)
    rows_done == rows_model + (out_valid && exp_last))
    else report_mismatch("rows_done", $sampled(rows_done),
                         $sampled(rows_model + (out_valid && exp_last)));

  // Credits spent never exceed the credits available
  assert property (@(posedge clk) disable iff (!rstn)
    outstanding + out_valid <= so_pkg::CREDIT_MAX)
    else report_problem("more outputs issued than credits allow");
  assert property (@(posedge clk) disable iff (!rstn)
    outstanding + out_valid == so_pkg::CREDIT_MAX && !out_credit |-> !in_ready)
    else report_mismatch("in_ready", $sampled(in_ready), 0);

  assert property (@(posedge clk) disable iff (!rstn)
    check_latency && in_valid && in_ready &&
    (in_word.op == so_pkg::OP_DATA || in_word.op == so_pkg::OP_DATA_LAST) |-> ##4 out_valid)
    else report_problem("out_valid did not follow an accepted data word after 4 cycles");

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    seed = 42627;
    credit_seed = seed;
    clk = 1'b0;
    rstn = 1'b0;
    in_valid = 1'b0;
    in_word = '0;
    out_credit = 1'b0;
    hold_credits = 1'b0;
    fast_credit = 1'b0;
    check_latency = 1'b0;
    errors = 0;
    checked = 0;
    cycles = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // Random arithmetic under changing scales
    for (i = 0; i < T2_WORDS; i++) begin
      if (i % 25 == 0) begin
        send_word(cfg_word(so_pkg::OP_CFG_MM, 32'(1 + rand_below(1 << 16)), 8'(rand_below(24))));
        send_word(cfg_word(so_pkg::OP_CFG_OUT, 32'(1 + rand_below(1 << 12)),
                           8'(6 + rand_below(16))));
      end
      if (i == 150)
        send_word(cfg_word(so_pkg::OP_CFG_MM, 32'd7, 8'd70));
      send_word(data_word(i % 16 == 15, 32'($random(seed)) >>> rand_below(28),
                          8'($random(seed))));
      if (rand_below(5) == 0)
        idle(1);
    end
    wait_drained();

    // Config between data words, earlier words keep the old scale
    send_word(cfg_word(so_pkg::OP_CFG_MM, 32'd3, 8'd1));
    send_word(cfg_word(so_pkg::OP_CFG_OUT, 32'd1, 8'd0));
    for (i = 1; i <= 4; i++)
      send_word(data_word(1'b0, 32'(10 * i), 8'd0));
    send_word(cfg_word(so_pkg::OP_CFG_MM, 32'd5, 8'd0));
    send_word(data_word(1'b0, 32'd10, 8'd0));
    send_word(data_word(1'b1, 32'd20, 8'hff));
    wait_drained();

    // Saturation at 22 bits and int8 clip
    send_word(cfg_word(so_pkg::OP_CFG_MM, 32'd1, 8'd0));
    send_word(data_word(1'b0, 32'h7fff_ffff, 8'h7f));
    send_word(data_word(1'b0, 32'h8000_0000, 8'h80));
    send_word(data_word(1'b0, 32'h001f_fff0, 8'h7f));
    send_word(cfg_word(so_pkg::OP_CFG_OUT, 32'd1, 8'd14));
    send_word(data_word(1'b0, 32'h7fff_ffff, 8'h00));
    send_word(data_word(1'b1, 32'h8000_0000, 8'hff));
    wait_drained();

    // Back-pressure with no credits returned
    @(posedge clk);
    hold_credits = 1'b1;
    fork
      begin
        for (int j = 0; j < HOLD_WORDS; j++)
          send_word(data_word(j == HOLD_WORDS - 1, 32'(32'h100 * j), 8'(j)));
      end
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        hold_credits = 1'b0;
      end
    join
    wait_drained();

    // Latency and row count at full rate
    send_word(cfg_word(so_pkg::OP_CFG_OUT, 32'd1, 8'd0));
    idle(1);
    fast_credit = 1'b1;
    check_latency = 1'b1;
    for (i = 0; i < ROWS * ROW_LEN; i++)
      send_word(data_word(i % ROW_LEN == ROW_LEN - 1, 32'(3 * i), 8'(i)));
    wait_drained();
    check_latency = 1'b0;
    fast_credit = 1'b0;

    repeat (4) @(negedge clk);
    $display("Outputs checked: %0d, errors: %0d", checked, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+dv
verilog/so_pkg.sv
verilog/so_data_if.sv
verilog/so_sum_if.sv
verilog/so_decode.sv
verilog/so_requant_add.sv
verilog/so_result.sv
verilog/self_output_top.sv
dv/tb_self_output.sv
